// File: hdl/wb_settings.svh
////////////////////
// Build-time sizing for the completion and retirement core
// Include wherever a size is needed; the package holds the types
////////////////////

`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Number of instruction IDs in flight
`define MAX_INFLIGHT 8

// Data path width
`define XLEN 32

// Units reporting completions to writeback
`define NUM_WB_UNITS 2

// Destination register address width
`define REG_ADDR_W 5

`endif

// File: hdl/wb_pkg.sv
////////////////////
// Shared types for the completion and retirement core
// Referenced by scoped name from every module
////////////////////

`include "wb_settings.svh"

package wb_pkg;

    localparam int ID_W = $clog2(`MAX_INFLIGHT);

    // Instruction ID
    typedef logic [ID_W-1:0] id_t;

    // Index into the unit writeback array
    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_id_t;

    // ALU operation, ignored by the multiplier
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5
    } alu_op_t;

    // Packet from the issue port
    typedef struct packed {
        unit_id_t                 unit;
        alu_op_t                  op;
        logic [`REG_ADDR_W-1:0]   rd_addr;
        logic [`XLEN-1:0]         src_a;
        logic [`XLEN-1:0]         src_b;
    } issue_pkt_t;

    // Request toward one unit
    typedef struct packed {
        logic             issue;
        id_t              id;
        alu_op_t          op;
        logic [`XLEN-1:0] src_a;
        logic [`XLEN-1:0] src_b;
    } unit_issue_t;

    // Completion reported by one unit
    typedef struct packed {
        logic             done;
        id_t              id;
        logic [`XLEN-1:0] rd;
    } unit_wb_t;

    // Retired result record
    typedef struct packed {
        id_t                      id;
        logic [`REG_ADDR_W-1:0]   rd_addr;
        logic [`XLEN-1:0]         rd_data;
    } retire_t;

endpackage

// File: hdl/id_tracker.sv
////////////////////
// Circular instruction ID allocator
// Hands out IDs in issue order and frees them in the same order
////////////////////

`timescale 1ns/1ns

`include "wb_settings.svh"

module id_tracker (
    input  logic         clk,
    input  logic         rst,
    input  logic         issued,
    input  logic         retired,
    output wb_pkg::id_t  next_id,
    output wb_pkg::id_t  oldest_id,
    output logic         id_available,
    output logic         empty
);

    // One extra bit so a full tracker is distinguishable from empty
    localparam int CNT_W = $clog2(`MAX_INFLIGHT) + 1;

    wb_pkg::id_t       next_ptr;
    wb_pkg::id_t       oldest_ptr;
    logic [CNT_W-1:0]  inflight_cnt;

    ////////////////////
    // Pointers

    // Both wrap naturally since the ID count is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            next_ptr   <= '0;
            oldest_ptr <= '0;
        end else begin
            if (issued)
                next_ptr <= next_ptr + 1'b1;
            if (retired)
                oldest_ptr <= oldest_ptr + 1'b1;
        end
    end

    ////////////////////
    // Occupancy

    // Simultaneous issue and retire leaves the count unchanged
    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_cnt <= '0;
        end else if (issued && !retired) begin
            inflight_cnt <= inflight_cnt + 1'b1;
        end else if (retired && !issued) begin
            inflight_cnt <= inflight_cnt - 1'b1;
        end
    end

    assign next_id      = next_ptr;
    assign oldest_id    = oldest_ptr;
    assign id_available = (inflight_cnt != CNT_W'(`MAX_INFLIGHT));
    assign empty        = (inflight_cnt == '0);

endmodule

// File: hdl/alu_unit.sv
////////////////////
// Single-cycle integer unit
// Completion is reported in the same cycle as the request
////////////////////

`timescale 1ns/1ns

`include "wb_settings.svh"

module alu_unit (
    input  wb_pkg::unit_issue_t  req,
    output wb_pkg::unit_wb_t     wb
);

    logic [`XLEN-1:0] result;
    logic [4:0]       shamt;

    // Shift amount from the low bits of operand b
    assign shamt = req.src_b[4:0];

    ////////////////////
    // Operation decode

    always_comb begin
        case (req.op)
            wb_pkg::ADD: begin
                result = req.src_a + req.src_b;
            end
            wb_pkg::SUB: begin
                result = req.src_a - req.src_b;
            end
            wb_pkg::AND: begin
                result = req.src_a & req.src_b;
            end
            wb_pkg::OR: begin
                result = req.src_a | req.src_b;
            end
            wb_pkg::XOR: begin
                result = req.src_a ^ req.src_b;
            end
            wb_pkg::SLL: begin
                result = req.src_a << shamt;
            end
            // Unused encodings give zero
            default: begin
                result = '0;
            end
        endcase
    end

    // Done straight from the issue strobe
    assign wb.done = req.issue;
    assign wb.id   = req.id;
    assign wb.rd   = result;

endmodule

// File: hdl/mul_unit.sv
////////////////////
// Iterative shift-add multiplier, one partial product per cycle
// Returns the low word of the product and blocks new work while busy
////////////////////

`timescale 1ns/1ns

`include "wb_settings.svh"

module mul_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  wb_pkg::unit_issue_t  req,
    output logic                 ready,
    output wb_pkg::unit_wb_t     wb
);

    localparam int CNT_W = $clog2(`XLEN + 1);

    logic              busy;
    logic [CNT_W-1:0]  step_cnt;
    logic              start;
    logic              finished;
    wb_pkg::id_t       id_r;
    logic [`XLEN-1:0]  mcand;
    logic [`XLEN-1:0]  mplier;
    logic [`XLEN-1:0]  acc;

    assign ready    = ~busy;
    assign start    = req.issue & ready;
    // Last cycle of the operation, all XLEN steps applied
    assign finished = busy && (step_cnt == CNT_W'(`XLEN));

    ////////////////////
    // Control

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            step_cnt <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            // First step is taken while latching
            step_cnt <= CNT_W'(1);
        end else if (finished) begin
            busy <= 1'b0;
        end else if (busy) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    ////////////////////
    // Datapath

    // Multiplicand moves left and multiplier right each step
    always_ff @(posedge clk) begin
        if (start) begin
            id_r   <= req.id;
            acc    <= req.src_b[0] ? req.src_a : '0;
            mcand  <= req.src_a << 1;
            mplier <= req.src_b >> 1;
        end else if (busy && !finished) begin
            acc    <= acc + (mplier[0] ? mcand : '0);
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Done is a one-cycle level from registered state
    assign wb.done = finished;
    assign wb.id   = id_r;
    assign wb.rd   = acc;

endmodule

// File: hdl/write_back.sv
////////////////////
// Issue acceptance, result buffer by ID and in-order retirement
// Units may finish in any order; results leave in issue order
////////////////////

`timescale 1ns/1ns

`include "wb_settings.svh"

module write_back (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 issue,
    input  wb_pkg::issue_pkt_t   issue_pkt,
    output logic                 issue_ready,

    input  wb_pkg::id_t          next_id,
    input  wb_pkg::id_t          oldest_id,
    input  logic                 id_available,
    output logic                 issued,
    output logic                 retired,

    output wb_pkg::unit_issue_t  alu_req,
    output wb_pkg::unit_issue_t  mul_req,
    input  logic                 mul_ready,
    input  wb_pkg::unit_wb_t     unit_wb [`NUM_WB_UNITS],

    output logic                 retire,
    output wb_pkg::retire_t      retire_rec
);

    localparam int N = `MAX_INFLIGHT;

    // Per-ID unit select
    wb_pkg::unit_id_t        unit_sel_r [N];
    wb_pkg::unit_id_t        unit_sel   [N];

    // Per-ID metadata and result buffer
    logic [`REG_ADDR_W-1:0]  rd_meta       [N];
    logic [`XLEN-1:0]        results_by_id [N];

    logic [N-1:0]            id_issued_oh;
    logic [N-1:0]            id_writing;
    logic [N-1:0]            id_inuse;
    logic [N-1:0]            id_pending;
    logic [N-1:0]            id_pending_r;
    logic [N-1:0]            id_retiring_oh;

    logic                    retiring;
    wb_pkg::id_t             id_retiring;
    logic                    to_mul;

    ////////////////////
    // Issue acceptance

    assign to_mul      = (issue_pkt.unit == wb_pkg::UNIT_MUL);
    // Multiplier busy only stalls multiplier packets
    assign issue_ready = id_available & (~to_mul | mul_ready);
    assign issued      = issue & issue_ready;

    // Same operands to both units, only one sees the strobe
    assign alu_req.issue = issued & ~to_mul;
    assign alu_req.id    = next_id;
    assign alu_req.op    = issue_pkt.op;
    assign alu_req.src_a = issue_pkt.src_a;
    assign alu_req.src_b = issue_pkt.src_b;

    assign mul_req.issue = issued & to_mul;
    assign mul_req.id    = next_id;
    assign mul_req.op    = issue_pkt.op;
    assign mul_req.src_a = issue_pkt.src_a;
    assign mul_req.src_b = issue_pkt.src_b;

    always_comb begin
        id_issued_oh          = '0;
        id_issued_oh[next_id] = issued;
    end

    ////////////////////
    // Completion detect

    // Any unit naming an ID as done writes that ID
    always_comb begin
        id_writing = '0;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < `NUM_WB_UNITS; j++) begin
                id_writing[i] |= unit_wb[j].done && (unit_wb[j].id == wb_pkg::id_t'(i));
            end
        end
    end

    ////////////////////
    // Unit select, metadata and result buffer

    for (genvar i = 0; i < N; i++) begin : g_id_slot
        always_ff @(posedge clk) begin
            if (id_issued_oh[i]) begin
                unit_sel_r[i] <= issue_pkt.unit;
                rd_meta[i]    <= issue_pkt.rd_addr;
            end
        end

        // Free ID falls back to the issuing unit
        // Catches the ALU finishing in its issue cycle
        assign unit_sel[i] = id_inuse[i] ? unit_sel_r[i] : issue_pkt.unit;

        always_ff @(posedge clk) begin
            if (id_writing[i])
                results_by_id[i] <= unit_wb[unit_sel[i]].rd;
        end
    end

    // Set at issue, cleared once written
    // Clear wins so a same-cycle ALU result never marks the ID in use
    always_ff @(posedge clk) begin
        if (rst)
            id_inuse <= '0;
        else
            id_inuse <= (id_inuse | id_issued_oh) & ~id_writing;
    end

    ////////////////////
    // Pending and retirement

    always_ff @(posedge clk) begin
        if (rst)
            id_pending_r <= '0;
        else
            id_pending_r <= id_pending;
    end

    // Result waiting in the buffer, dropped in the retire cycle
    assign id_pending = id_writing | (id_pending_r & ~id_retiring_oh);

    // Oldest ID ready means it retires next cycle
    assign retired = id_pending[oldest_id];

    always_ff @(posedge clk) begin
        if (rst)
            retiring <= 1'b0;
        else
            retiring <= retired;
    end

    always_ff @(posedge clk) begin
        id_retiring <= oldest_id;
    end

    always_comb begin
        id_retiring_oh              = '0;
        id_retiring_oh[id_retiring] = retiring;
    end

    // Record read from the buffer by the registered ID
    assign retire             = retiring;
    assign retire_rec.id      = id_retiring;
    assign retire_rec.rd_addr = rd_meta[id_retiring];
    assign retire_rec.rd_data = results_by_id[id_retiring];

endmodule

// File: hdl/wb_core_top.sv
////////////////////
// Top of the completion and retirement core
// Connects the ID tracker, both units and the writeback block
////////////////////

`timescale 1ns/1ns

`include "wb_settings.svh"

module wb_core_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue,
    input  wb_pkg::issue_pkt_t  issue_pkt,
    output logic                issue_ready,
    output logic                retire,
    output wb_pkg::retire_t     retire_rec,
    output logic                empty
);

    wb_pkg::id_t          next_id;
    wb_pkg::id_t          oldest_id;
    logic                 id_available;
    logic                 issued;
    logic                 retired;
    logic                 mul_ready;
    wb_pkg::unit_issue_t  alu_req;
    wb_pkg::unit_issue_t  mul_req;
    // Index 0 ALU, index 1 multiplier
    wb_pkg::unit_wb_t     unit_wb [`NUM_WB_UNITS];

    id_tracker id_tracker_i (
        .clk          (clk),
        .rst          (rst),
        .issued       (issued),
        .retired      (retired),
        .next_id      (next_id),
        .oldest_id    (oldest_id),
        .id_available (id_available),
        .empty        (empty)
    );

    alu_unit alu_unit_i (
        .req (alu_req),
        .wb  (unit_wb[0])
    );

    mul_unit mul_unit_i (
        .clk   (clk),
        .rst   (rst),
        .req   (mul_req),
        .ready (mul_ready),
        .wb    (unit_wb[1])
    );

    write_back write_back_i (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .issue_pkt    (issue_pkt),
        .issue_ready  (issue_ready),
        .next_id      (next_id),
        .oldest_id    (oldest_id),
        .id_available (id_available),
        .issued       (issued),
        .retired      (retired),
        .alu_req      (alu_req),
        .mul_req      (mul_req),
        .mul_ready    (mul_ready),
        .unit_wb      (unit_wb),
        .retire       (retire),
        .retire_rec   (retire_rec)
    );

endmodule

// File: dv/wb_core_tb.sv
////////////////////
// Testbench for the completion and retirement core
// Random issue stream checked against an in-order reference queue
////////////////////

`timescale 1ns/1ns

`include "wb_settings.svh"

module wb_core_tb;

    localparam int CLK_PERIOD = 20;
    localparam bit [31:0] SEED = 32'h5c86_01b7;

    // Instruction counts per phase
    localparam int N_ALU      = 40;
    localparam int N_MUL      = 12;
    localparam int N_PAIR     = 6;
    localparam int N_MIXED    = 30;
    localparam int N_FILL_ALU = 10;
    localparam int N_BURST    = 30;
    localparam int TOTAL_INSTR = N_ALU + N_MUL + 2 * N_PAIR + N_MIXED
                               + 1 + N_FILL_ALU + N_BURST;
    localparam int WATCHDOG_CYCLES = TOTAL_INSTR * (`XLEN + 4) + 200;

    logic                clk;
    logic                rst;
    logic                issue;
    wb_pkg::issue_pkt_t  issue_pkt;
    logic                issue_ready;
    logic                retire;
    wb_pkg::retire_t     retire_rec;
    logic                empty;

    // Expected records in issue order
    wb_pkg::retire_t     exp_q [$];
    int                  issue_seq;
    int                  outstanding;
    int                  max_outstanding;
    // Cycles left in which the multiplier still holds ready low
    int                  mul_left;

    wb_core_top wb_core_top_i (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .issue_pkt   (issue_pkt),
        .issue_ready (issue_ready),
        .retire      (retire),
        .retire_rec  (retire_rec),
        .empty       (empty)
    );

    ////////////////////
    // Clock and reset

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst       = 1'b1;
        issue     = 1'b0;
        issue_pkt = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
    end

    ////////////////////
    // Failure reporting

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_record(input wb_pkg::retire_t got, input wb_pkg::retire_t exp);
        if (got !== exp) begin
            fail_run($sformatf(
                "ERR @%0t: retire id %0d addr %0d data %08h, expected id %0d addr %0d data %08h",
                $time, got.id, got.rd_addr, got.rd_data, exp.id, exp.rd_addr, exp.rd_data));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR @%0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    ////////////////////
    // Reference model

    // ALU rules per op; multiplier keeps the low word of the product
    function automatic logic [`XLEN-1:0] expected_result(input wb_pkg::issue_pkt_t pkt);
        logic [`XLEN-1:0] r;
        if (pkt.unit == wb_pkg::UNIT_MUL) begin
            r = pkt.src_a * pkt.src_b;
        end else begin
            case (pkt.op)
                wb_pkg::ADD: r = pkt.src_a + pkt.src_b;
                wb_pkg::SUB: r = pkt.src_a - pkt.src_b;
                wb_pkg::AND: r = pkt.src_a & pkt.src_b;
                wb_pkg::OR:  r = pkt.src_a | pkt.src_b;
                wb_pkg::XOR: r = pkt.src_a ^ pkt.src_b;
                wb_pkg::SLL: r = pkt.src_a << pkt.src_b[4:0];
                default:     r = '0;
            endcase
        end
        return r;
    endfunction

    function automatic wb_pkg::issue_pkt_t random_packet(input wb_pkg::unit_id_t unit);
        wb_pkg::issue_pkt_t p;
        p.unit    = unit;
        p.op      = wb_pkg::alu_op_t'($urandom_range(5, 0));
        p.rd_addr = `REG_ADDR_W'($urandom);
        p.src_a   = $urandom;
        p.src_b   = $urandom;
        return p;
    endfunction

    // Roughly one multiply in four
    function automatic wb_pkg::unit_id_t random_unit();
        return ($urandom_range(3, 0) == 0) ? wb_pkg::UNIT_MUL : wb_pkg::UNIT_ALU;
    endfunction

    ////////////////////
    // Stimulus helpers

    // Retries every cycle until issue_ready allows the packet
    task automatic drive_one(input wb_pkg::issue_pkt_t pkt, input int gap);
        bit              accepted;
        wb_pkg::retire_t rec;
        accepted = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #2;
            issue = 1'b0;
        end
        while (!accepted) begin
            @(posedge clk);
            #2;
            issue     = 1'b0;
            issue_pkt = pkt;
            #1;
            if (issue_ready) begin
                issue       = 1'b1;
                // IDs are handed out in order from zero
                rec.id      = wb_pkg::id_t'(issue_seq);
                rec.rd_addr = pkt.rd_addr;
                rec.rd_data = expected_result(pkt);
                exp_q.push_back(rec);
                issue_seq++;
                accepted = 1'b1;
            end
        end
    endtask

    task automatic wait_drain();
        @(posedge clk);
        #2;
        issue = 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);
    endtask

    ////////////////////
    // Main sequence

    initial begin
        void'($urandom(SEED));
        issue_seq       = 0;
        outstanding     = 0;
        max_outstanding = 0;
        mul_left        = 0;
        @(negedge rst);
        repeat (3) @(posedge clk);

        // ALU only with random gaps
        for (int i = 0; i < N_ALU; i++)
            drive_one(random_packet(wb_pkg::UNIT_ALU), $urandom_range(3, 0));
        wait_drain();

        // Multiplier only
        for (int i = 0; i < N_MUL; i++)
            drive_one(random_packet(wb_pkg::UNIT_MUL), $urandom_range(3, 0));
        wait_drain();

        // Younger ALU right behind a multiply
        for (int i = 0; i < N_PAIR; i++) begin
            drive_one(random_packet(wb_pkg::UNIT_MUL), 0);
            drive_one(random_packet(wb_pkg::UNIT_ALU), 0);
        end
        for (int i = 0; i < N_MIXED; i++)
            drive_one(random_packet(random_unit()), $urandom_range(2, 0));
        wait_drain();

        // Back-to-back issue with a multiply at the head to fill the tracker
        drive_one(random_packet(wb_pkg::UNIT_MUL), 0);
        for (int i = 0; i < N_FILL_ALU; i++)
            drive_one(random_packet(wb_pkg::UNIT_ALU), 0);
        for (int i = 0; i < N_BURST; i++)
            drive_one(random_packet(random_unit()), 0);
        wait_drain();

        if (max_outstanding != `MAX_INFLIGHT) begin
            fail_run($sformatf("Tracker never filled: peak of %0d instructions outstanding",
                               max_outstanding));
        end else if (exp_q.size() != 0 || outstanding != 0) begin
            fail_run("Instructions still outstanding at the end of the run");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

    ////////////////////
    // Compare process

    // Samples at the falling edge away from input changes
    initial begin
        wb_pkg::retire_t exp_rec;
        logic            exp_ready;
        @(negedge rst);
        forever begin
            @(negedge clk);
            if (retire && exp_q.size() == 0) begin
                fail_run("Retire pulsed with no instruction outstanding");
            end else begin
                if (retire) begin
                    exp_rec = exp_q.pop_front();
                    check_record(retire_rec, exp_rec);
                    outstanding--;
                end
                // Tracker frees an ID by the cycle its record appears
                check_level("empty", empty, outstanding == 0);
                // Ready needs a free ID and an idle multiplier for a multiply
                exp_ready = (outstanding < `MAX_INFLIGHT) &&
                            (issue_pkt.unit != wb_pkg::UNIT_MUL || mul_left == 0);
                check_level("issue_ready", issue_ready, exp_ready);
                if (mul_left > 0)
                    mul_left--;
                if (issue && issue_ready) begin
                    outstanding++;
                    if (outstanding > max_outstanding)
                        max_outstanding = outstanding;
                    // Busy from the next cycle through the done cycle
                    if (issue_pkt.unit == wb_pkg::UNIT_MUL)
                        mul_left = `XLEN;
                end
            end
        end
    end

    ////////////////////
    // Watchdog

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("Watchdog expired because retirement stalled before all instructions retired");
    end

endmodule

// File: wb_core.f
+incdir+hdl
hdl/wb_pkg.sv
hdl/id_tracker.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/write_back.sv
hdl/wb_core_top.sv
dv/wb_core_tb.sv

// File: Makefile
# Verilator build for the completion and retirement core

VERILATOR ?= verilator
TOP       ?= wb_core_tb
FILELIST  ?= wb_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST RESULT: PASS
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, not the simulator exit code
run: compile
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
